// ==== common/uart_pkg.sv ====
`default_nettype none

// shared constants and types for the uart echo link.
package uart_pkg;

  // clock cycles in one bit period, kept small so simulation runs fast.
  localparam int clks_per_bit = 16;

  // offset from the detected start edge to the middle of the start bit.
  localparam int half_bit = (clks_per_bit - 1) / 2;

  // width of the bit-period counters in the receive and transmit stages.
  localparam int cnt_w = $clog2(clks_per_bit);

  // number of byte entries held between the receive and transmit stages.
  localparam int fifo_depth = 4;

  // line status seen at the top level.
  typedef struct packed {
    logic frame_err;  // one-cycle pulse, stop bit sampled low.
    logic overrun;    // sticky, a byte was dropped on a full fifo.
  } line_status_t;

endpackage

`default_nettype wire

// ==== uart/uart_rx.sv ====
`timescale 1ns/1ns
`default_nettype none

// receive stage of the echo link.
// the serial line is brought into the clock domain by two flops, a falling edge
// starts a frame, and every bit is sampled near the middle of its period.
module uart_rx (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       rx,         // asynchronous serial input, idle high.
  output logic       rx_valid,   // one-cycle pulse, rx_data holds a good byte.
  output logic [7:0] rx_data,
  output logic       frame_err   // one-cycle pulse, stop bit was low.
);

  import uart_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_start,
    st_data,
    st_stop
  } rx_state_t;

  rx_state_t        state;
  logic [cnt_w-1:0] cnt;       // cycles elapsed in the current bit period.
  logic [2:0]       bit_idx;   // index of the data bit being sampled.
  logic             rx_meta;   // first synchronizer flop.
  logic             rx_sync;   // second synchronizer flop, safe to use.
  logic             bit_end;   // last cycle of a full bit period.
  logic             mid_start; // middle of the start bit.
  logic [7:0]       shreg;     // byte under assembly, LSB arrives first.

  // both flops come out of reset high, so the reset release is not a start bit.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
    end
  end

  assign bit_end   = (cnt == cnt_w'(clks_per_bit - 1));
  assign mid_start = (cnt == cnt_w'(half_bit));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= st_idle;
      cnt       <= '0;
      bit_idx   <= '0;
      rx_valid  <= 1'b0;
      frame_err <= 1'b0;
    end else begin
      rx_valid  <= 1'b0;  // both strobes last one cycle only.
      frame_err <= 1'b0;

      case (state)
        st_idle: begin
          cnt     <= '0;
          bit_idx <= '0;
          if (!rx_sync) state <= st_start;  // falling edge seen.
        end

        st_start: begin
          // a line that is high again by mid-bit was only a glitch.
          if (mid_start) begin
            cnt <= '0;
            if (!rx_sync) state <= st_data;
            else          state <= st_idle;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end

        st_data: begin
          if (bit_end) begin
            cnt <= '0;  // the shift register takes the bit in this cycle.
            if (bit_idx == 3'd7) begin
              state <= st_stop;
            end else begin
              bit_idx <= bit_idx + 1'b1;
            end
          end else begin
            cnt <= cnt + 1'b1;
          end
        end

        st_stop: begin
          if (bit_end) begin
            cnt       <= '0;
            rx_valid  <= rx_sync;   // good stop bit.
            frame_err <= !rx_sync;  // the byte is discarded.
            state     <= st_idle;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end

        default: state <= st_idle;
      endcase
    end
  end

  // data bits enter at the top and move down, so bit 0 ends in the LSB.
  always_ff @(posedge clk) begin
    if (state == st_data && bit_end) begin
      shreg <= {rx_sync, shreg[7:1]};
    end
  end

  // the byte stays stable until the next frame's first data sample.
  assign rx_data = shreg;

endmodule

`default_nettype wire

// ==== uart/uart_tx.sv ====
`timescale 1ns/1ns
`default_nettype none

// transmit stage of the echo link.
// takes one byte from the fifo when allowed and sends a start bit, eight data
// bits with the LSB first, and a stop bit.
module uart_tx (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       data_ready,  // the fifo holds at least one byte.
  input  logic [7:0] data,        // head byte of the fifo.
  input  logic       tx_hold,     // level, no new frame starts while high.
  output logic       pop,         // one-cycle pulse, byte taken from the fifo.
  output logic       tx,          // serial output, idle high.
  output logic       busy         // high for the whole frame.
);

  import uart_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_start,
    st_data,
    st_stop
  } tx_state_t;

  tx_state_t        state;
  logic [cnt_w-1:0] cnt;      // cycles elapsed in the current bit period.
  logic [2:0]       bit_idx;  // data bit now on the line.
  logic             bit_end;  // last cycle of the bit on the line.
  logic [7:0]       shreg;    // bits still waiting to go out.

  assign bit_end = (cnt == cnt_w'(clks_per_bit - 1));

  // a hold never cuts a frame short, it only blocks the next pop.
  assign pop  = (state == st_idle) && data_ready && !tx_hold;
  assign busy = (state != st_idle);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= st_idle;
      cnt     <= '0;
      bit_idx <= '0;
      tx      <= 1'b1;
    end else begin
      case (state)
        st_idle: begin
          cnt     <= '0;
          bit_idx <= '0;
          tx      <= !pop;  // start bit goes out the cycle after pop.
          if (pop) state <= st_start;
        end

        st_start: begin
          if (bit_end) begin
            cnt   <= '0;
            tx    <= shreg[0];
            state <= st_data;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end

        st_data: begin
          if (bit_end) begin
            cnt <= '0;
            if (bit_idx == 3'd7) begin
              tx    <= 1'b1;  // stop bit.
              state <= st_stop;
            end else begin
              tx      <= shreg[0];  // shreg already holds the next bit in its LSB.
              bit_idx <= bit_idx + 1'b1;
            end
          end else begin
            cnt <= cnt + 1'b1;
          end
        end

        st_stop: begin
          // busy drops after this period and a new pop may follow at once.
          if (bit_end) begin
            cnt   <= '0;
            state <= st_idle;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end

        default: state <= st_idle;
      endcase
    end
  end

  // the byte is loaded on pop, then moves down one place per bit handed to tx.
  always_ff @(posedge clk) begin
    if (pop) begin
      shreg <= data;
    end else if (bit_end && (state == st_start || state == st_data)) begin
      shreg <= {1'b1, shreg[7:1]};
    end
  end

endmodule

`default_nettype wire

// ==== design/byte_fifo.sv ====
`timescale 1ns/1ns
`default_nettype none

// small circular byte buffer between the receive and transmit stages.
module byte_fifo (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       push,       // one-cycle strobe from the receiver.
  input  logic [7:0] push_data,
  input  logic       pop,        // one-cycle strobe from the transmitter.
  output logic [7:0] head_data,  // oldest byte, valid while empty is low.
  output logic       empty,
  output logic       overrun     // sticky until reset.
);

  import uart_pkg::*;

  logic [7:0]                      mem [fifo_depth];
  logic [$clog2(fifo_depth)-1:0]   wr_ptr;
  logic [$clog2(fifo_depth)-1:0]   rd_ptr;
  logic [$clog2(fifo_depth+1)-1:0] count;  // bytes now stored.
  logic                            full;
  logic                            push_ok;
  logic                            pop_ok;

  assign full    = (count == fifo_depth);
  assign empty   = (count == '0);
  assign push_ok = push && !full;  // a push on a full buffer is lost.
  assign pop_ok  = pop && !empty;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      overrun <= 1'b0;
    end else begin
      if (push_ok) begin
        // wrap by hand so any depth works, not only powers of two.
        wr_ptr <= (wr_ptr == fifo_depth - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr <= (rd_ptr == fifo_depth - 1) ? '0 : rd_ptr + 1'b1;
      end

      // a push and a pop in the same cycle leave the count where it was.
      case ({push_ok, pop_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase

      if (push && full) overrun <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (push_ok) mem[wr_ptr] <= push_data;
  end

  assign head_data = mem[rd_ptr];

endmodule

`default_nettype wire

// ==== design/uart_echo_top.sv ====
`timescale 1ns/1ns
`default_nettype none

// uart echo link.
// bytes received on rx are buffered and sent back on tx in arrival order,
// with tx_hold acting as a clear-to-send line on the transmit side.
module uart_echo_top (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    rx,
  input  logic                    tx_hold,
  output logic                    tx,
  output logic                    busy,
  output uart_pkg::line_status_t  status
);

  logic       rx_valid;    // good byte from the receiver.
  logic [7:0] rx_data;
  logic       frame_err;   // bad stop bit seen.
  logic [7:0] fifo_data;   // head of the buffer.
  logic       fifo_empty;
  logic       overrun;
  logic       pop;         // transmitter took the head byte.

  uart_rx u_rx (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx        (rx),
    .rx_valid  (rx_valid),
    .rx_data   (rx_data),
    .frame_err (frame_err)
  );

  byte_fifo u_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (rx_valid),
    .push_data (rx_data),
    .pop       (pop),
    .head_data (fifo_data),
    .empty     (fifo_empty),
    .overrun   (overrun)
  );

  // the transmitter wants to know when a byte is there, not when none is.
  uart_tx u_tx (
    .clk        (clk),
    .rst_n      (rst_n),
    .data_ready (!fifo_empty),
    .data       (fifo_data),
    .tx_hold    (tx_hold),
    .pop        (pop),
    .tx         (tx),
    .busy       (busy)
  );

  assign status = '{frame_err: frame_err, overrun: overrun};  // both bits from the stages.

endmodule

`default_nettype wire

// ==== tb/tb_uart_echo.sv ====
`timescale 1ns/1ns
`default_nettype none

// testbench for the uart echo link.
// a serial driver feeds rx, a serial monitor decodes tx, and random bytes
// come from a galois lfsr.
module tb_uart_echo;

  import uart_pkg::*;

  localparam int frame_cycles    = 10 * clks_per_bit;  // start, 8 data and stop bits.
  localparam int watchdog_cycles = 40000;

  logic         clk;
  logic         rst_n;
  logic         rx;
  logic         tx_hold;
  logic         tx;
  logic         busy;
  line_status_t status;

  logic [7:0]   exp_q[$];              // bytes that must still come back on tx.
  logic [15:0]  lfsr_state = 16'd20;
  int           mismatch_count = 0;
  int           timeout_count = 0;
  int           other_count = 0;
  int           cycle = 0;             // free running clock count.
  int           ferr_count = 0;        // frame_err pulses seen so far.
  int           ferr_cycle = 0;        // cycle of the latest frame_err pulse.
  int           busy_len = 0;          // length of the busy run now open.
  logic         expect_quiet = 1'b0;   // tx must stay high while this is set.

  uart_echo_top u_dut (
    .clk     (clk),
    .rst_n   (rst_n),
    .rx      (rx),
    .tx_hold (tx_hold),
    .tx      (tx),
    .busy    (busy),
    .status  (status)
  );

  always #2 clk = ~clk;

  always @(posedge clk) cycle <= cycle + 1;

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("MISMATCH %s expected 0x%0h actual 0x%0h at %0t", name, expected, actual, $time);
    mismatch_count++;
  endtask

  task automatic report_timeout(input string what);
    $display("timeout while waiting for %s at %0t", what, $time);
    timeout_count++;
  endtask

  task automatic report_failure(input string what);
    $display("error: %s at %0t", what, $time);
    other_count++;
  endtask

  // 16-bit galois lfsr, one step gives one random bit.
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    lfsr_step = s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  task automatic next_rand_byte(output logic [7:0] b);
    int i;
    for (i = 0; i < 8; i++) begin
      b[i]       = lfsr_state[0];  // the bit leaving the register.
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  // holds one level on rx for a whole bit period.
  task automatic drive_bit(input logic v);
    @(posedge clk);
    rx <= v;
    repeat (clks_per_bit - 1) @(posedge clk);
  endtask

  task automatic send_frame(input logic [7:0] b, input logic good_stop);
    int i;
    drive_bit(1'b0);
    for (i = 0; i < 8; i++) drive_bit(b[i]);  // LSB first.
    drive_bit(good_stop);
    if (!good_stop) drive_bit(1'b1);  // line back to idle after a bad stop.
  endtask

  // a low pulse well short of half a bit, then a quiet line.
  task automatic send_glitch();
    @(posedge clk);
    rx <= 1'b0;
    repeat (half_bit - 3) @(posedge clk);
    rx <= 1'b1;
    repeat (2 * clks_per_bit) @(posedge clk);
  endtask

  // decodes one frame on tx and checks it against the head of exp_q.
  task automatic receive_frame(input int limit, input logic expect_none);
    int         waited;
    int         i;
    logic [7:0] b;
    logic [7:0] expected;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (tx !== 1'b0 && waited < limit);
    if (tx !== 1'b0) begin
      if (!expect_none) report_timeout("a start bit on tx");
    end else begin
      repeat (half_bit) @(negedge clk);  // now near the middle of the start bit.
      assert (tx === 1'b0) else report_mismatch("tx start bit", 32'd0, 32'(tx));
      for (i = 0; i < 8; i++) begin
        repeat (clks_per_bit) @(negedge clk);
        b[i] = tx;
      end
      repeat (clks_per_bit) @(negedge clk);
      assert (tx === 1'b1) else report_mismatch("tx stop bit", 32'd1, 32'(tx));
      if (expect_none || exp_q.size() == 0) begin
        report_failure("a byte came out on tx where none was due");
      end else begin
        expected = exp_q.pop_front();
        assert (b === expected) else report_mismatch("tx byte", 32'(expected), 32'(b));
      end
    end
  endtask

  // sends n random bytes back to back while the monitor checks each echo.
  task automatic echo_random(input int n);
    logic [7:0] b;
    int         i;
    int         j;
    fork
      begin
        for (i = 0; i < n; i++) begin
          next_rand_byte(b);
          exp_q.push_back(b);
          send_frame(b, 1'b1);
        end
      end
      begin
        for (j = 0; j < n; j++) receive_frame(2 * frame_cycles, 1'b0);
      end
    join
  endtask

  // sends n bytes under tx_hold, of which only the first kept come back.
  task automatic send_held(input int n, input int kept);
    logic [7:0] b;
    int         i;
    @(posedge clk);
    tx_hold      <= 1'b1;
    expect_quiet = 1'b1;
    for (i = 0; i < n; i++) begin
      next_rand_byte(b);
      if (i < kept) exp_q.push_back(b);
      send_frame(b, 1'b1);
    end
    drive_bit(1'b1);  // lets the last byte settle in the fifo.
    expect_quiet = 1'b0;
    tx_hold      <= 1'b0;
    for (i = 0; i < kept; i++) receive_frame(2 * frame_cycles, 1'b0);
  endtask

  // busy has to cover exactly one frame, and frame_err pulses are logged here.
  always @(negedge clk) begin
    if (busy) begin
      busy_len = busy_len + 1;
    end else if (busy_len != 0) begin
      assert (busy_len == frame_cycles)
        else report_mismatch("busy length", frame_cycles, busy_len);
      busy_len = 0;
    end
    if (status.frame_err) begin
      ferr_count++;
      ferr_cycle = cycle;
    end
    if (expect_quiet) begin
      assert (tx === 1'b1) else report_mismatch("tx while held", 32'd1, 32'(tx));
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n) !busy |-> tx)
    else report_mismatch("tx when idle", 32'd1, 32'($sampled(tx)));

  assert property (@(posedge clk) disable iff (!rst_n) $rose(busy) |-> $past(!tx_hold))
    else report_failure("a frame started while tx_hold was high");

  assert property (@(posedge clk) disable iff (!rst_n)
                   $past(status.frame_err) |-> !status.frame_err)
    else report_mismatch("status.frame_err", 32'd0, 32'($sampled(status.frame_err)));

  assert property (@(posedge clk) disable iff (!rst_n)
                   $past(status.overrun) |-> status.overrun)
    else report_mismatch("status.overrun", 32'd1, 32'($sampled(status.overrun)));

  initial begin
    int i;
    int t0;
    int ferr_before;
    int waited;
    clk     = 1'b0;
    rst_n   = 1'b0;
    rx      = 1'b1;
    tx_hold = 1'b0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    // quiet line right after reset.
    for (i = 0; i < 2 * clks_per_bit; i++) begin
      @(negedge clk);
      assert (tx === 1'b1) else report_mismatch("tx", 32'd1, 32'(tx));
      assert (busy === 1'b0) else report_mismatch("busy", 32'd0, 32'(busy));
      assert (status === '0) else report_mismatch("status", 32'd0, 32'(status));
    end

    echo_random(20);

    // a bad stop bit gives one frame_err pulse and no echo.
    ferr_before = ferr_count;
    @(negedge clk);
    t0 = cycle;
    fork
      send_frame(8'h5a, 1'b0);
      receive_frame(2 * frame_cycles, 1'b1);
    join
    waited = 0;
    while (ferr_count == ferr_before && waited < frame_cycles) begin
      @(posedge clk);
      waited++;
    end
    if (ferr_count == ferr_before) begin
      report_timeout("frame_err after a bad stop bit");
    end else begin
      assert (ferr_count == ferr_before + 1)
        else report_mismatch("frame_err pulses", ferr_before + 1, ferr_count);
      assert (ferr_cycle - t0 >= 9 * clks_per_bit && ferr_cycle - t0 <= 11 * clks_per_bit)
        else report_mismatch("frame_err delay", 19 * clks_per_bit / 2, ferr_cycle - t0);
    end
    echo_random(1);

    // a short glitch is a false start.
    ferr_before = ferr_count;
    fork
      send_glitch();
      receive_frame(2 * frame_cycles, 1'b1);
    join
    assert (ferr_count == ferr_before)
      else report_mismatch("frame_err pulses", ferr_before, ferr_count);
    echo_random(1);

    send_held(fifo_depth, fifo_depth);
    @(negedge clk);
    assert (status.overrun === 1'b0)
      else report_mismatch("status.overrun", 32'd0, 32'(status.overrun));

    // two bytes more than the fifo holds are lost.
    send_held(fifo_depth + 2, fifo_depth);
    receive_frame(3 * frame_cycles, 1'b1);  // nothing more is due here.
    @(negedge clk);
    assert (status.overrun === 1'b1)
      else report_mismatch("status.overrun", 32'd1, 32'(status.overrun));
    assert (exp_q.size() == 0) else report_mismatch("bytes not echoed", 32'd0, exp_q.size());

    $display("errors: %0d mismatches, %0d timeouts, %0d other", mismatch_count, timeout_count,
             other_count);
    if (mismatch_count + timeout_count + other_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // overall limit, in case a wait escapes its own timeout.
  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("timeout: the test sequence did not finish in %0d cycles", watchdog_cycles);
    $display("errors: %0d mismatches, %0d timeouts, %0d other", mismatch_count,
             timeout_count + 1, other_count);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
common/uart_pkg.sv
uart/uart_rx.sv
uart/uart_tx.sv
design/byte_fifo.sv
design/uart_echo_top.sv
tb/tb_uart_echo.sv

// ==== Makefile ====
# Verilator lint, build and run for the uart echo testbench.
# Any variable can be set on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_uart_echo
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --assert --timing -Wno-fatal
LINTFLAGS ?= --lint-only -Wall --assert --timing
FAIL_MSG  ?= Simulation finished: FAIL
PASS_MSG  ?= Simulation finished: PASS

SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "simulation ended without a verdict, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
